/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_id_stage
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
rtl/id_pkg.sv
rtl/regfile.sv
rtl/id_stage_reg.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_resolve.sv
rtl/id_stage.sv
testbench/id_checker.sv
testbench/id_stage_props.sv
testbench/tb_id_stage.sv

/* rtl/branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import id_pkg::*; (
    input  logic                valid,
    input  logic                stall,
    input  logic [BR_KINDS-1:0] br_kind,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     rj_value,
    input  logic [XLEN-1:0]     rkd_value,
    input  logic [XLEN-1:0]     br_offs,
    output logic                br_taken,
    output logic [XLEN-1:0]     br_target
);

    logic [XLEN:0] diff;
    logic          rj_eq;
    logic          rj_lt_s;
    logic          rj_lt_u;
    logic          cond;

    // borrow out of the widened subtract gives unsigned less-than
    assign diff    = {1'b0, rj_value} - {1'b0, rkd_value};
    assign rj_eq   = (rj_value == rkd_value);
    assign rj_lt_u = diff[XLEN];
    assign rj_lt_s = (rj_value[XLEN-1] != rkd_value[XLEN-1]) ? rj_value[XLEN-1] : diff[XLEN-1];

    assign cond = (br_kind[BR_BEQ]  &&  rj_eq)   ||
                  (br_kind[BR_BNE]  && !rj_eq)   ||
                  (br_kind[BR_BLT]  &&  rj_lt_s) ||
                  (br_kind[BR_BGE]  && !rj_lt_s) ||
                  (br_kind[BR_BLTU] &&  rj_lt_u) ||
                  (br_kind[BR_BGEU] && !rj_lt_u) ||
                  br_kind[BR_B] || br_kind[BR_BL] || br_kind[BR_JIRL];

    assign br_taken  = valid && !stall && cond;
    assign br_target = br_kind[BR_JIRL] ? (rj_value + br_offs) : (pc + br_offs);

endmodule

`default_nettype wire

/* rtl/id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // one-hot alu operation, bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [11:0] alu_op_t;

    // branch classes, one-hot
    localparam int BR_BEQ   = 0;
    localparam int BR_BNE   = 1;
    localparam int BR_BLT   = 2;
    localparam int BR_BGE   = 3;
    localparam int BR_BLTU  = 4;
    localparam int BR_BGEU  = 5;
    localparam int BR_B     = 6;
    localparam int BR_BL    = 7;
    localparam int BR_JIRL  = 8;
    localparam int BR_KINDS = 9;

    // inst[31:26]
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] OP4_REG    = 4'h0;
    localparam logic [3:0] OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_LD_W   = 4'h2;
    localparam logic [3:0] OP4_ST_W   = 4'h6;
    localparam logic [3:0] OP4_SLTI   = 4'h8;
    localparam logic [3:0] OP4_SLTUI  = 4'h9;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [3:0] OP4_ANDI   = 4'hd;
    localparam logic [3:0] OP4_ORI    = 4'he;
    localparam logic [3:0] OP4_XORI   = 4'hf;

    // inst[21:20]
    localparam logic [1:0] OP2_SHIFTI = 2'h0;
    localparam logic [1:0] OP2_REG    = 2'h1;

    // inst[19:15]
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLL  = 5'h0e;
    localparam logic [4:0] OP5_SRL  = 5'h0f;
    localparam logic [4:0] OP5_SRA  = 5'h10;
    localparam logic [4:0] OP5_SRAI = 5'h11;

    typedef union packed {
        struct packed {
            logic [16:0]           op_hi;
            logic [REG_ADDR_W-1:0] rk;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } r;
        struct packed {
            logic [9:0]            op;
            logic [11:0]           i12;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } i;
    } inst_u;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } fwd_t;

    typedef struct packed {
        inst_u           inst;
        logic [XLEN-1:0] pc;
    } if_id_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [XLEN-1:0]       alu_src1;
        logic [XLEN-1:0]       alu_src2;
        logic                  rf_we;
        logic [REG_ADDR_W-1:0] rf_waddr;
        logic [XLEN-1:0]       st_data;
        logic                  mem_re;
        logic                  mem_we;
    } id_ex_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] raddr1;
        logic [REG_ADDR_W-1:0] raddr2;
        logic                  need_r1;
        logic                  need_r2;
    } reg_use_t;

endpackage

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = 32'h1c00_0000
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_valid,
    input  if_id_t          in_data,
    output logic            allowin,
    output logic            out_valid,
    output id_ex_t          out_data,
    input  logic            ex_allowin,
    input  fwd_t            ex_fwd,
    input  fwd_t            mem_fwd,
    input  fwd_t            wb_fwd,
    input  logic            ex_is_load,
    output logic            br_taken,
    output logic [XLEN-1:0] br_target
);

    logic                  valid;
    logic                  stall;
    if_id_t                cur;
    reg_use_t              reg_use;
    logic [XLEN-1:0]       rj_value;
    logic [XLEN-1:0]       rkd_value;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       alu_src1;
    logic [XLEN-1:0]       alu_src2;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  mem_re;
    logic                  mem_we;
    logic [BR_KINDS-1:0]   br_kind;
    logic [XLEN-1:0]       br_offs;

    id_stage_reg #(
        .PC_RESET (PC_RESET)
    ) u_stage_reg (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .ex_allowin (ex_allowin),
        .stall      (stall),
        .br_taken   (br_taken),
        .allowin    (allowin),
        .valid      (valid),
        .out_valid  (out_valid),
        .cur        (cur)
    );

    inst_decoder u_decoder (
        .inst      (cur.inst),
        .pc        (cur.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .alu_op    (alu_op),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .reg_use   (reg_use),
        .br_kind   (br_kind),
        .br_offs   (br_offs)
    );

    operand_forward u_forward (
        .clk        (clk),
        .reg_use    (reg_use),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .valid      (valid),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .stall      (stall)
    );

    branch_resolve u_branch (
        .valid     (valid),
        .stall     (stall),
        .br_kind   (br_kind),
        .pc        (cur.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .br_offs   (br_offs),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    // store data is the forwarded rd value
    assign out_data = '{
        alu_op:   alu_op,
        alu_src1: alu_src1,
        alu_src2: alu_src2,
        rf_we:    rf_we,
        rf_waddr: rf_waddr,
        st_data:  rkd_value,
        mem_re:   mem_re,
        mem_we:   mem_we
    };

endmodule

`default_nettype wire

/* rtl/id_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_reg import id_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = '0
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   in_valid,
    input  if_id_t in_data,
    input  logic   ex_allowin,
    input  logic   stall,
    input  logic   br_taken,
    output logic   allowin,
    output logic   valid,
    output logic   out_valid,
    output if_id_t cur
);

    if_id_t cur_q;

    assign allowin   = !valid || (!stall && ex_allowin);
    assign out_valid = valid && !stall;

    // taken branch leaves with ex_allowin, whatever follows is dropped
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (br_taken && ex_allowin) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            cur_q <= in_data;
        end
    end

    assign cur = valid ? cur_q : '{inst: '0, pc: PC_RESET};

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  inst_u                 inst,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       rj_value,
    input  logic [XLEN-1:0]       rkd_value,
    output alu_op_t               alu_op,
    output logic [XLEN-1:0]       alu_src1,
    output logic [XLEN-1:0]       alu_src2,
    output logic                  rf_we,
    output logic [REG_ADDR_W-1:0] rf_waddr,
    output logic                  mem_re,
    output logic                  mem_we,
    output reg_use_t              reg_use,
    output logic [BR_KINDS-1:0]   br_kind,
    output logic [XLEN-1:0]       br_offs
);

    // opcode fields, split over the two views
    wire [5:0] op6 = inst.i.op[9:4];
    wire [3:0] op4 = inst.i.op[3:0];
    wire [1:0] op2 = inst.r.op_hi[6:5];
    wire [4:0] op5 = inst.r.op_hi[4:0];

    wire [11:0] i12 = inst.i.i12;
    wire [15:0] i16 = inst[25:10];
    wire [19:0] i20 = inst[24:5];
    wire [25:0] i26 = {inst[9:0], inst[25:10]};

    wire is_reg3   = (op6 == OP6_ALU) && (op4 == OP4_REG) && (op2 == OP2_REG);
    wire is_shifti = (op6 == OP6_ALU) && (op4 == OP4_SHIFTI) && (op2 == OP2_SHIFTI);

    wire inst_add_w  = is_reg3 && (op5 == OP5_ADD);
    wire inst_sub_w  = is_reg3 && (op5 == OP5_SUB);
    wire inst_slt    = is_reg3 && (op5 == OP5_SLT);
    wire inst_sltu   = is_reg3 && (op5 == OP5_SLTU);
    wire inst_nor    = is_reg3 && (op5 == OP5_NOR);
    wire inst_and    = is_reg3 && (op5 == OP5_AND);
    wire inst_or     = is_reg3 && (op5 == OP5_OR);
    wire inst_xor    = is_reg3 && (op5 == OP5_XOR);
    wire inst_sll_w  = is_reg3 && (op5 == OP5_SLL);
    wire inst_srl_w  = is_reg3 && (op5 == OP5_SRL);
    wire inst_sra_w  = is_reg3 && (op5 == OP5_SRA);

    wire inst_slli_w = is_shifti && (op5 == OP5_SLLI);
    wire inst_srli_w = is_shifti && (op5 == OP5_SRLI);
    wire inst_srai_w = is_shifti && (op5 == OP5_SRAI);

    wire inst_addi_w = (op6 == OP6_ALU) && (op4 == OP4_ADDI);
    wire inst_slti   = (op6 == OP6_ALU) && (op4 == OP4_SLTI);
    wire inst_sltui  = (op6 == OP6_ALU) && (op4 == OP4_SLTUI);
    wire inst_andi   = (op6 == OP6_ALU) && (op4 == OP4_ANDI);
    wire inst_ori    = (op6 == OP6_ALU) && (op4 == OP4_ORI);
    wire inst_xori   = (op6 == OP6_ALU) && (op4 == OP4_XORI);

    // bit 25 set is outside the u12i encodings
    wire inst_lu12i_w   = (op6 == OP6_LU12I) && !inst[25];
    wire inst_pcaddu12i = (op6 == OP6_PCADDU12I) && !inst[25];

    wire inst_ld_w = (op6 == OP6_MEM) && (op4 == OP4_LD_W);
    wire inst_st_w = (op6 == OP6_MEM) && (op4 == OP4_ST_W);

    wire inst_jirl = (op6 == OP6_JIRL);
    wire inst_b    = (op6 == OP6_B);
    wire inst_bl   = (op6 == OP6_BL);
    wire inst_beq  = (op6 == OP6_BEQ);
    wire inst_bne  = (op6 == OP6_BNE);
    wire inst_blt  = (op6 == OP6_BLT);
    wire inst_bge  = (op6 == OP6_BGE);
    wire inst_bltu = (op6 == OP6_BLTU);
    wire inst_bgeu = (op6 == OP6_BGEU);

    wire reg3_alu = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and |
                    inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    wire shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;
    wire imm_alu  = inst_addi_w | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori |
                    shift_imm;
    wire cond_br  = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    wire need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w | shift_imm;
    wire need_si20 = inst_lu12i_w | inst_pcaddu12i;
    wire need_si26 = inst_b | inst_bl;
    wire src2_is_4 = inst_jirl | inst_bl;

    wire src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;
    wire src2_is_imm = imm_alu | inst_ld_w | inst_st_w | need_si20 | src2_is_4;
    wire rd_as_src2  = cond_br | inst_st_w;

    logic [XLEN-1:0] imm;

    assign alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w |
                              inst_jirl | inst_bl | inst_pcaddu12i;
    assign alu_op[ALU_SUB]  = inst_sub_w;
    assign alu_op[ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
    assign alu_op[ALU_AND]  = inst_and | inst_andi;
    assign alu_op[ALU_NOR]  = inst_nor;
    assign alu_op[ALU_OR]   = inst_or | inst_ori;
    assign alu_op[ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
    assign alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
    assign alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
    assign alu_op[ALU_LUI]  = inst_lu12i_w;

    // link value is pc + 4
    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {i20, 12'b0} :
                 need_si12 ? {{20{i12[11]}}, i12} :
                             {20'b0, i12};

    assign br_offs = need_si26 ? {{4{i26[25]}}, i26, 2'b0} :
                                 {{14{i16[15]}}, i16, 2'b0};

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    assign rf_we    = reg3_alu | imm_alu | need_si20 | inst_ld_w | inst_jirl | inst_bl;
    assign rf_waddr = inst_bl ? REG_ADDR_W'(1) : inst.i.rd;
    assign mem_re   = inst_ld_w;
    assign mem_we   = inst_st_w;

    assign reg_use.raddr1  = inst.i.rj;
    assign reg_use.raddr2  = rd_as_src2 ? inst.i.rd : inst.r.rk;
    assign reg_use.need_r1 = reg3_alu | imm_alu | inst_ld_w | inst_st_w | cond_br | inst_jirl;
    assign reg_use.need_r2 = reg3_alu | inst_st_w | cond_br;

    assign br_kind[BR_BEQ]  = inst_beq;
    assign br_kind[BR_BNE]  = inst_bne;
    assign br_kind[BR_BLT]  = inst_blt;
    assign br_kind[BR_BGE]  = inst_bge;
    assign br_kind[BR_BLTU] = inst_bltu;
    assign br_kind[BR_BGEU] = inst_bgeu;
    assign br_kind[BR_B]    = inst_b;
    assign br_kind[BR_BL]   = inst_bl;
    assign br_kind[BR_JIRL] = inst_jirl;

endmodule

`default_nettype wire

/* rtl/operand_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_forward import id_pkg::*; (
    input  logic            clk,
    input  reg_use_t        reg_use,
    input  fwd_t            ex_fwd,
    input  fwd_t            mem_fwd,
    input  fwd_t            wb_fwd,
    input  logic            ex_is_load,
    input  logic            valid,
    output logic [XLEN-1:0] rj_value,
    output logic [XLEN-1:0] rkd_value,
    output logic            stall
);

    logic [XLEN-1:0] rf_rdata1;
    logic [XLEN-1:0] rf_rdata2;

    function automatic logic hit(input fwd_t src, input logic [REG_ADDR_W-1:0] raddr);
        return src.we && (raddr != '0) && (src.waddr == raddr);
    endfunction

    // ex over mem over wb over the array
    function automatic logic [XLEN-1:0] pick(
        input logic [REG_ADDR_W-1:0] raddr,
        input logic [XLEN-1:0]       rf_data,
        input fwd_t                  ex,
        input fwd_t                  mem,
        input fwd_t                  wb
    );
        if (hit(ex, raddr)) begin
            return ex.wdata;
        end else if (hit(mem, raddr)) begin
            return mem.wdata;
        end else if (hit(wb, raddr)) begin
            return wb.wdata;
        end
        return rf_data;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (reg_use.raddr1),
        .raddr2 (reg_use.raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (wb_fwd)
    );

    assign rj_value  = pick(reg_use.raddr1, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign rkd_value = pick(reg_use.raddr2, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    // load data not yet available in ex
    assign stall = valid && ex_is_load &&
                   ((reg_use.need_r1 && hit(ex_fwd, reg_use.raddr1)) ||
                    (reg_use.need_r2 && hit(ex_fwd, reg_use.raddr2)));

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile import id_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  fwd_t                  wr
);

    logic [XLEN-1:0] mem [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (wr.we && (wr.waddr != '0)) begin
            mem[wr.waddr] <= wr.wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

endmodule

`default_nettype wire

/* testbench/id_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module id_checker import id_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            allowin,
    input  logic            out_valid,
    input  id_ex_t          out_data,
    input  logic            ex_allowin,
    input  logic            br_taken,
    input  logic [XLEN-1:0] br_target
);

    int err_count = 0;
    int xfer_count = 0;

    alu_op_t               exp_alu [$];
    logic [XLEN-1:0]       exp_src1 [$];
    logic [XLEN-1:0]       exp_src2 [$];
    logic [REG_ADDR_W-1:0] exp_waddr [$];
    logic                  exp_taken [$];
    logic [XLEN-1:0]       exp_target [$];

    logic   held;
    id_ex_t held_data;

    task automatic push_expected(input alu_op_t alu, input logic [XLEN-1:0] s1,
                                 input logic [XLEN-1:0] s2, input logic [REG_ADDR_W-1:0] wa,
                                 input logic tk, input logic [XLEN-1:0] tgt);
        exp_alu.push_back(alu);
        exp_src1.push_back(s1);
        exp_src2.push_back(s2);
        exp_waddr.push_back(wa);
        exp_taken.push_back(tk);
        exp_target.push_back(tgt);
    endtask

    task automatic compare(input string what, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            err_count = err_count + 1;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_stalled();
        if (out_valid !== 1'b0 || allowin !== 1'b0) begin
            err_count = err_count + 1;
            $display("Fail %0t: no load-use stall, out_valid %b allowin %b",
                     $time, out_valid, allowin);
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            held = 1'b0;
        end else if (out_valid && ex_allowin) begin
            xfer_count = xfer_count + 1;
            held = 1'b0;
            if (exp_alu.size() == 0) begin
                err_count = err_count + 1;
                $display("an unexpected downstream transfer happened at %0t", $time);
            end else begin
                compare("alu_op", XLEN'(out_data.alu_op), XLEN'(exp_alu.pop_front()));
                compare("alu_src1", out_data.alu_src1, exp_src1.pop_front());
                compare("alu_src2", out_data.alu_src2, exp_src2.pop_front());
                compare("rf_waddr", XLEN'(out_data.rf_waddr), XLEN'(exp_waddr.pop_front()));
                compare("br_taken", XLEN'(br_taken), XLEN'(exp_taken[0]));
                // target only matters when taken
                if (exp_taken.pop_front()) begin
                    compare("br_target", br_target, exp_target[0]);
                end
                void'(exp_target.pop_front());
            end
        end else if (out_valid) begin
            if (held) begin
                compare("held out_data", XLEN'(out_data != held_data), '0);
            end
            held = 1'b1;
            held_data = out_data;
        end else begin
            held = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* testbench/id_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_props import id_pkg::*; (
    input logic   clk,
    input logic   resetn,
    input logic   in_valid,
    input logic   allowin,
    input logic   out_valid,
    input logic   ex_allowin,
    input logic   ex_is_load,
    input logic   br_taken,
    input id_ex_t out_data
);

    a_reset_quiet: assert property (@(posedge clk) !resetn |=> !out_valid && !br_taken)
        else $error("stage output active right after reset");

    // back-pressure holds the bundle and blocks upstream
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !ex_allowin |-> !allowin ##1 (!out_valid || $stable(out_data)))
        else $error("stage changed or accepted under back-pressure");

    a_rise: assert property (@(posedge clk) disable iff (!resetn)
        $rose(out_valid) |-> $past(in_valid && allowin) || $past(ex_is_load))
        else $error("out_valid rose without an upstream transfer");

endmodule

bind id_stage id_stage_props u_props (
    .clk        (clk),
    .resetn     (resetn),
    .in_valid   (in_valid),
    .allowin    (allowin),
    .out_valid  (out_valid),
    .ex_allowin (ex_allowin),
    .ex_is_load (ex_is_load),
    .br_taken   (br_taken),
    .out_data   (out_data)
);

`default_nettype wire

/* testbench/id_stimulus.txt */
# seen inst pc | ex we addr data | mem we addr data | wb we addr data | ex_is_load
# expected: alu_op src1 src2 rf_waddr br_taken br_target (seen 0 = flushed behind a branch)
1 02800000 1c000000 0 00 00000000 0 00 00000000 1 01 00000010 0 001 00000000 00000000 00 0 0
1 02800000 1c000004 0 00 00000000 0 00 00000000 1 02 fffffff0 0 001 00000000 00000000 00 0 0
1 02800000 1c000008 0 00 00000000 0 00 00000000 1 03 00000003 0 001 00000000 00000000 00 0 0
1 02800000 1c00000c 0 00 00000000 0 00 00000000 1 06 00001000 0 001 00000000 00000000 00 0 0
1 00100827 1c000010 0 00 00000000 0 00 00000000 0 00 00000000 0 001 00000010 fffffff0 07 0 0
1 00110c28 1c000014 0 00 00000000 0 00 00000000 0 00 00000000 0 002 00000010 00000003 08 0 0
1 00141849 1c000018 0 00 00000000 0 00 00000000 0 00 00000000 0 020 fffffff0 00001000 09 0 0
1 00180c4a 1c00001c 0 00 00000000 0 00 00000000 0 00 00000000 0 400 fffffff0 00000003 0a 0 0
1 02bffc4b 1c000020 0 00 00000000 0 00 00000000 0 00 00000000 0 001 fffffff0 ffffffff 0b 0 0
1 037ffc4c 1c000024 0 00 00000000 0 00 00000000 0 00 00000000 0 010 fffffff0 00000fff 0c 0 0
1 00408c2d 1c000028 0 00 00000000 0 00 00000000 0 00 00000000 0 100 00000010 00000023 0d 0 0
1 1c00002e 1c00002c 0 00 00000000 0 00 00000000 0 00 00000000 0 001 1c00002c 00001000 0e 0 0
1 288020cf 1c000030 0 00 00000000 0 00 00000000 0 00 00000000 0 001 00001000 00000008 0f 0 0
1 29bff0c3 1c000034 0 00 00000000 0 00 00000000 0 00 00000000 0 001 00001000 fffffffc 03 0 0
1 00128450 1c000038 0 00 00000000 0 00 00000000 0 00 00000000 0 008 fffffff0 00000010 10 0 0
1 00100c31 1c00003c 1 01 aaaa0001 1 01 bbbb0001 1 03 cccc0003 0 001 aaaa0001 cccc0003 11 0 0
1 00151832 1c000040 0 00 00000000 1 06 bbbb0006 1 06 cccc0006 0 040 00000010 bbbb0006 12 0 0
1 00100013 1c000044 1 00 deadbeef 0 00 00000000 0 00 00000000 0 001 00000000 00000000 13 0 0
1 00100834 1c000048 1 02 00000077 0 00 00000000 0 00 00000000 1 001 00000010 00000077 14 0 0
1 60004041 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 000 fffffff0 00000010 01 1 1c000140
0 00100435 1c000104 0 00 00000000 0 00 00000000 0 00 00000000 0 000 00000000 00000000 00 0 0
1 68004041 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 000 fffffff0 00000010 01 0 0
1 6ffff041 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 000 fffffff0 00000010 01 1 1c0000f0
0 00100435 1c000104 0 00 00000000 0 00 00000000 0 00 00000000 0 000 00000000 00000000 00 0 0
1 54040000 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 001 1c000100 00000004 01 1 1c000500
0 00100435 1c000104 0 00 00000000 0 00 00000000 0 00 00000000 0 000 00000000 00000000 00 0 0
1 4c0004c2 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 001 1c000100 00000004 02 1 cccc000a
0 00100435 1c000104 0 00 00000000 0 00 00000000 0 00 00000000 0 000 00000000 00000000 00 0 0
1 58004022 1c000100 0 00 00000000 0 00 00000000 0 00 00000000 0 000 00000010 fffffff0 02 0 0

/* testbench/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    localparam int MAX_VEC      = 64;
    localparam int NUM_FIELDS   = 19;
    localparam int RESET_CYCLES = 10;

    logic            clk;
    logic            resetn;
    logic            in_valid;
    if_id_t          in_data;
    logic            allowin;
    logic            out_valid;
    id_ex_t          out_data;
    logic            ex_allowin;
    fwd_t            ex_fwd;
    fwd_t            mem_fwd;
    fwd_t            wb_fwd;
    logic            ex_is_load;
    logic            br_taken;
    logic [XLEN-1:0] br_target;

    // one row per vector in the order of the stimulus file columns
    logic [31:0] vec [MAX_VEC][NUM_FIELDS];
    int          n_vec;
    int          pushed;
    int          cycles;
    int          limit;
    logic        rand_bp;

    id_stage #(
        .PC_RESET (32'h1c00_0000)
    ) i_dut (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .ex_allowin (ex_allowin),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    id_checker i_chk (
        .clk        (clk),
        .resetn     (resetn),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .ex_allowin (ex_allowin),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random back-pressure once out of reset
    always @(negedge clk) begin
        if (rand_bp) begin
            ex_allowin = (($urandom % 4) != 0);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the DUT did not finish the vectors within %0d cycles", limit);
            $display("errors: %0d", i_chk.err_count);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic read_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [NUM_FIELDS];
        fd = $fopen("testbench/id_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/id_stimulus.txt");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
                    if (cnt == NUM_FIELDS) begin
                        vec[n_vec] = f;
                        n_vec = n_vec + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_inputs(input int i);
        in_data    = '{inst: vec[i][1], pc: vec[i][2]};
        ex_fwd     = '{we: vec[i][3][0], waddr: vec[i][4][4:0], wdata: vec[i][5]};
        mem_fwd    = '{we: vec[i][6][0], waddr: vec[i][7][4:0], wdata: vec[i][8]};
        wb_fwd     = '{we: vec[i][9][0], waddr: vec[i][10][4:0], wdata: vec[i][11]};
        ex_is_load = vec[i][12][0];
    endtask

    // returns on the falling edge after the upstream transfer
    task automatic wait_upstream();
        logic took;
        took = 1'b0;
        while (!took) begin
            #1;
            took = allowin;
            @(negedge clk);
        end
    endtask

    task automatic run_vector(input int i);
        @(negedge clk);
        apply_inputs(i);
        in_valid = 1'b1;
        i_chk.push_expected(vec[i][13][11:0], vec[i][14], vec[i][15], vec[i][16][4:0],
                            vec[i][17][0], vec[i][18]);
        pushed = pushed + 1;
        wait_upstream();
        in_valid = 1'b0;
        // next vector sits behind a taken branch and must vanish
        if (i + 1 < n_vec && vec[i + 1][0][0] == 1'b0) begin
            in_data  = '{inst: vec[i + 1][1], pc: vec[i + 1][2]};
            in_valid = 1'b1;
            wait_upstream();
            in_valid = 1'b0;
        end
        if (ex_is_load) begin
            repeat (3) begin
                #1;
                i_chk.check_stalled();
                @(negedge clk);
            end
            ex_is_load = 1'b0;
        end
        while (i_chk.xfer_count < pushed) begin
            @(negedge clk);
        end
    endtask

    initial begin
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        ex_allowin = 1'b1;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb_fwd     = '0;
        ex_is_load = 1'b0;
        rand_bp    = 1'b0;
        n_vec      = 0;
        pushed     = 0;
        cycles     = 0;
        limit      = 0;
        void'($urandom(32'h2b2ea692));
        read_vectors();
        limit = 40 * n_vec + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn  = 1'b1;
        rand_bp = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            if (vec[i][0][0]) begin
                run_vector(i);
            end
        end
        repeat (4) @(negedge clk);
        $display("vectors: %0d, transfers: %0d, errors: %0d",
                 n_vec, i_chk.xfer_count, i_chk.err_count);
        if (i_chk.err_count == 0 && i_chk.xfer_count == pushed && n_vec > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
